// File: logic/mdu_pkg.sv
package mdu_pkg;

	// operand width and request tag width
	localparam int XLEN  = 32;
	localparam int TAG_W = 4;

	typedef logic [XLEN-1:0] word_t;

	// funct3 field of the M extension
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_div    = 3'd4,
		op_divu   = 3'd5,
		op_rem    = 3'd6,
		op_remu   = 3'd7
	} mdu_op_e;

	// one request, 71 bits
	typedef struct packed {
		mdu_op_e          op;
		logic [TAG_W-1:0] tag;
		word_t            rs1;
		word_t            rs2;
	} mdu_req_t;

	// one result, 36 bits
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		word_t            value;
	} mdu_res_t;

endpackage : mdu_pkg

// File: logic/op_queue.sv
`timescale 1ns/10ps

module op_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output payload_t pop_data_o,
	output logic     full_o,
	output logic     empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             do_push;
	logic             do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full_o     = (count_q == CNT_W'(DEPTH));
	assign empty_o    = (count_q == '0);
	assign do_push    = push_i && !full_o;
	assign do_pop     = pop_i && !empty_o;
	assign pop_data_o = mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr_q] <= push_data_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			// push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule : op_queue

// File: logic/shift_add_multiplier.sv
`timescale 1ns/10ps

module shift_add_multiplier import mdu_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              start_i,
	input  logic              signed_a_i,
	input  logic              signed_b_i,
	input  word_t             a_i,
	input  word_t             b_i,
	output logic              done_o,
	output logic [2*XLEN-1:0] product_o
);

	localparam int CNT_W = $clog2(XLEN);

	logic              a_neg;
	logic              b_neg;
	word_t             a_mag;
	word_t             b_mag;
	logic              busy_q;
	logic [CNT_W-1:0]  step_q;
	logic              last_step;
	logic              neg_q;
	word_t             mcand_q;
	word_t             hi_q;
	word_t             lo_q;
	logic [XLEN:0]     sum;
	logic [2*XLEN-1:0] acc_next;

	// work on magnitudes, the sign is applied at the end
	assign a_neg = signed_a_i && a_i[XLEN-1];
	assign b_neg = signed_b_i && b_i[XLEN-1];
	assign a_mag = a_neg ? -a_i : a_i;
	assign b_mag = b_neg ? -b_i : b_i;

	// lo holds the remaining multiplier bits, lsb first
	assign sum       = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mcand_q} : '0);
	assign acc_next  = {sum, lo_q[XLEN-1:1]};
	assign last_step = (step_q == CNT_W'(XLEN - 1));

	assign product_o = {hi_q, lo_q};

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			step_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				step_q <= '0;
			end else if (busy_q) begin
				step_q <= step_q + 1'b1;
				if (last_step) begin
					busy_q <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			mcand_q <= a_mag;
			hi_q    <= '0;
			lo_q    <= b_mag;
			neg_q   <= a_neg ^ b_neg;
		end else if (busy_q) begin
			// final step also folds in the sign
			if (last_step && neg_q)
				{hi_q, lo_q} <= -acc_next;
			else
				{hi_q, lo_q} <= acc_next;
		end
	end

endmodule : shift_add_multiplier

// File: logic/restoring_divider.sv
`timescale 1ns/10ps

module restoring_divider import mdu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  start_i,
	input  logic  signed_i,
	input  word_t dividend_i,
	input  word_t divisor_i,
	output logic  done_o,
	output word_t quotient_o,
	output word_t remainder_o
);

	localparam int CNT_W = $clog2(XLEN);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_fix
	} state_e;

	state_e           state_q;
	logic [CNT_W-1:0] step_q;
	logic             n_neg;
	logic             d_neg;
	word_t            n_mag;
	word_t            d_mag;
	word_t            num_q;
	word_t            dmag_q;
	word_t            quo_q;
	word_t            rem_q;
	logic             q_neg_q;
	logic             r_neg_q;
	logic             zero_q;
	logic             ovf_q;
	logic [XLEN:0]    shifted;
	logic [XLEN+1:0]  diff;

	assign n_neg = signed_i && dividend_i[XLEN-1];
	assign d_neg = signed_i && divisor_i[XLEN-1];
	assign n_mag = n_neg ? -dividend_i : dividend_i;
	assign d_mag = d_neg ? -divisor_i : divisor_i;

	// bring down the next dividend bit and try the subtraction
	assign shifted = {rem_q, quo_q[XLEN-1]};
	assign diff    = {1'b0, shifted} - {2'b00, dmag_q};

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
			step_q  <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				state_q <= st_run;
				step_q  <= '0;
			end else begin
				case (state_q)
					st_run: begin
						step_q <= step_q + 1'b1;
						if (step_q == CNT_W'(XLEN - 1))
							state_q <= st_fix;
					end
					st_fix: begin
						state_q <= st_idle;
						done_o  <= 1'b1;
					end
					default: state_q <= st_idle;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			num_q   <= dividend_i;
			dmag_q  <= d_mag;
			quo_q   <= n_mag;
			rem_q   <= '0;
			q_neg_q <= n_neg ^ d_neg;
			r_neg_q <= n_neg;
			zero_q  <= (divisor_i == '0);
			ovf_q   <= signed_i && (dividend_i == {1'b1, {(XLEN-1){1'b0}}}) &&
				(divisor_i == '1);
		end else if (state_q == st_run) begin
			// restore on borrow
			if (!diff[XLEN+1]) begin
				rem_q <= diff[XLEN-1:0];
				quo_q <= {quo_q[XLEN-2:0], 1'b1};
			end else begin
				rem_q <= shifted[XLEN-1:0];
				quo_q <= {quo_q[XLEN-2:0], 1'b0};
			end
		end else if (state_q == st_fix) begin
			if (zero_q) begin
				quotient_o  <= '1;
				remainder_o <= num_q;
			end else if (ovf_q) begin
				quotient_o  <= num_q;
				remainder_o <= '0;
			end else begin
				quotient_o  <= q_neg_q ? -quo_q : quo_q;
				remainder_o <= r_neg_q ? -rem_q : rem_q;
			end
		end
	end

endmodule : restoring_divider

// File: logic/mdu_dispatch.sv
`timescale 1ns/10ps

module mdu_dispatch import mdu_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              req_empty_i,
	input  mdu_req_t          req_data_i,
	output logic              req_pop_o,
	input  logic              res_full_i,
	output logic              res_push_o,
	output mdu_res_t          res_data_o,
	output logic              mul_start_o,
	output logic              mul_signed_a_o,
	output logic              mul_signed_b_o,
	input  logic              mul_done_i,
	input  logic [2*XLEN-1:0] mul_product_i,
	output logic              div_start_o,
	output logic              div_signed_o,
	input  logic              div_done_i,
	input  word_t             div_quotient_i,
	input  word_t             div_remainder_i
);

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_push
	} state_e;

	state_e           state_q;
	mdu_op_e          op_q;
	logic [TAG_W-1:0] tag_q;
	word_t            value_q;
	logic             is_div;
	logic             eng_done;
	word_t            result;

	// one request in flight, and its result slot is free before the pop
	assign req_pop_o = (state_q == st_idle) && !req_empty_i && !res_full_i;

	// ops 4 to 7 go to the divider
	assign is_div      = req_data_i.op[2];
	assign mul_start_o = req_pop_o && !is_div;
	assign div_start_o = req_pop_o && is_div;

	// engines sample the queue head in the popping cycle
	always_comb begin
		mul_signed_a_o = 1'b0;
		mul_signed_b_o = 1'b0;
		case (req_data_i.op)
			op_mulh: begin
				mul_signed_a_o = 1'b1;
				mul_signed_b_o = 1'b1;
			end
			op_mulhsu: mul_signed_a_o = 1'b1;
			default: ;
		endcase
	end

	assign div_signed_o = (req_data_i.op == op_div) || (req_data_i.op == op_rem);

	assign eng_done = op_q[2] ? div_done_i : mul_done_i;

	always_comb begin
		case (op_q)
			op_mul:          result = mul_product_i[XLEN-1:0];
			op_mulh,
			op_mulhsu,
			op_mulhu:        result = mul_product_i[2*XLEN-1:XLEN];
			op_div, op_divu: result = div_quotient_i;
			default:         result = div_remainder_i;
		endcase
	end

	assign res_push_o = (state_q == st_push);
	assign res_data_o = '{tag: tag_q, value: value_q};

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: if (req_pop_o) state_q <= st_busy;
				st_busy: if (eng_done) state_q <= st_push;
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_pop_o) begin
			op_q  <= req_data_i.op;
			tag_q <= req_data_i.tag;
		end
		if (state_q == st_busy && eng_done)
			value_q <= result;
	end

endmodule : mdu_dispatch

// File: logic/result_sender.sv
`timescale 1ns/10ps

module result_sender import mdu_pkg::*; (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             res_credit_i,
	input  logic             empty_i,
	input  mdu_res_t         data_i,
	output logic             pop_o,
	output logic             res_valid_o,
	output logic [TAG_W-1:0] res_tag_o,
	output word_t            res_value_o
);

	localparam int CREDIT_W = 8;

	logic [CREDIT_W-1:0] credit_q;
	logic                send;

	// one result per cycle while credits last
	assign send  = (credit_q != '0) && !empty_i;
	assign pop_o = send;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			credit_q    <= '0;
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= send;
			case ({res_credit_i, send})
				2'b10:   credit_q <= credit_q + 1'b1;
				2'b01:   credit_q <= credit_q - 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			res_tag_o   <= data_i.tag;
			res_value_o <= data_i.value;
		end
	end

endmodule : result_sender

// File: logic/mdu_top.sv
`timescale 1ns/10ps

module mdu_top import mdu_pkg::*; #(
	parameter int REQ_DEPTH = 4,
	parameter int RES_DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             req_valid_i,
	input  mdu_op_e          req_op_i,
	input  logic [TAG_W-1:0] req_tag_i,
	input  word_t            req_rs1_i,
	input  word_t            req_rs2_i,
	output logic             req_credit_o,
	input  logic             res_credit_i,
	output logic             res_valid_o,
	output logic [TAG_W-1:0] res_tag_o,
	output word_t            res_value_o
);

	mdu_req_t          req_in;
	mdu_req_t          req_head;
	logic              req_empty;
	logic              req_pop;
	mdu_res_t          res_in;
	mdu_res_t          res_head;
	logic              res_full;
	logic              res_empty;
	logic              res_push;
	logic              res_pop;
	logic              mul_start;
	logic              mul_signed_a;
	logic              mul_signed_b;
	logic              mul_done;
	logic [2*XLEN-1:0] mul_product;
	logic              div_start;
	logic              div_signed;
	logic              div_done;
	word_t             div_quotient;
	word_t             div_remainder;

	assign req_in       = '{op: req_op_i, tag: req_tag_i, rs1: req_rs1_i, rs2: req_rs2_i};
	assign req_credit_o = req_pop;

	// upstream credits keep this queue from overflowing
	op_queue #(
		.payload_t (mdu_req_t),
		.DEPTH     (REQ_DEPTH)
	) req_queue (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (req_valid_i),
		.push_data_i (req_in),
		.pop_i       (req_pop),
		.pop_data_o  (req_head),
		.full_o      (),
		.empty_o     (req_empty)
	);

	op_queue #(
		.payload_t (mdu_res_t),
		.DEPTH     (RES_DEPTH)
	) res_queue (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.push_i      (res_push),
		.push_data_i (res_in),
		.pop_i       (res_pop),
		.pop_data_o  (res_head),
		.full_o      (res_full),
		.empty_o     (res_empty)
	);

	mdu_dispatch mdu_dispatch_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.req_empty_i     (req_empty),
		.req_data_i      (req_head),
		.req_pop_o       (req_pop),
		.res_full_i      (res_full),
		.res_push_o      (res_push),
		.res_data_o      (res_in),
		.mul_start_o     (mul_start),
		.mul_signed_a_o  (mul_signed_a),
		.mul_signed_b_o  (mul_signed_b),
		.mul_done_i      (mul_done),
		.mul_product_i   (mul_product),
		.div_start_o     (div_start),
		.div_signed_o    (div_signed),
		.div_done_i      (div_done),
		.div_quotient_i  (div_quotient),
		.div_remainder_i (div_remainder)
	);

	// operands come straight from the request queue head
	shift_add_multiplier shift_add_multiplier_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.start_i    (mul_start),
		.signed_a_i (mul_signed_a),
		.signed_b_i (mul_signed_b),
		.a_i        (req_head.rs1),
		.b_i        (req_head.rs2),
		.done_o     (mul_done),
		.product_o  (mul_product)
	);

	restoring_divider restoring_divider_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.start_i     (div_start),
		.signed_i    (div_signed),
		.dividend_i  (req_head.rs1),
		.divisor_i   (req_head.rs2),
		.done_o      (div_done),
		.quotient_o  (div_quotient),
		.remainder_o (div_remainder)
	);

	result_sender result_sender_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.res_credit_i (res_credit_i),
		.empty_i      (res_empty),
		.data_i       (res_head),
		.pop_o        (res_pop),
		.res_valid_o  (res_valid_o),
		.res_tag_o    (res_tag_o),
		.res_value_o  (res_value_o)
	);

endmodule : mdu_top

// File: testbench/mdu_model.svh
`ifndef MDU_MODEL_SVH
`define MDU_MODEL_SVH

// mul family, taken from a full 64-bit product
function automatic logic [31:0] model_mul(input logic [2:0] op, input logic [31:0] a,
	input logic [31:0] b);
	logic [63:0] sa;
	logic [63:0] sb;
	logic [63:0] ua;
	logic [63:0] ub;
	logic [63:0] prod;
	sa = {{32{a[31]}}, a};
	sb = {{32{b[31]}}, b};
	ua = {32'd0, a};
	ub = {32'd0, b};
	case (op)
		3'd2:    prod = sa * ub;
		3'd3:    prod = ua * ub;
		default: prod = sa * sb;
	endcase
	// only mul keeps the low word
	if (op == 3'd0)
		return prod[31:0];
	return prod[63:32];
endfunction

// truncating division with the RISC-V corner cases
function automatic logic [31:0] model_div(input logic [2:0] op, input logic [31:0] a,
	input logic [31:0] b);
	longint sa;
	longint sb;
	longint q;
	longint r;
	logic   is_rem;
	logic   is_signed;
	is_rem    = (op == 3'd6) || (op == 3'd7);
	is_signed = (op == 3'd4) || (op == 3'd6);
	if (b == 32'd0)
		return is_rem ? a : 32'hffff_ffff;
	if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff)
		return is_rem ? 32'd0 : a;
	if (is_signed) begin
		sa = longint'($signed(a));
		sb = longint'($signed(b));
	end else begin
		sa = longint'(a);
		sb = longint'(b);
	end
	q = sa / sb;
	r = sa % sb;
	return is_rem ? r[31:0] : q[31:0];
endfunction

function automatic logic [31:0] model_result(input logic [2:0] op, input logic [31:0] a,
	input logic [31:0] b);
	return op[2] ? model_div(op, a, b) : model_mul(op, a, b);
endfunction

`endif

// File: testbench/mdu_tb.sv
`timescale 1ns/10ps

module mdu_tb import mdu_pkg::*; ();

	localparam int REQ_DEPTH = 4;
	localparam int RES_DEPTH = 4;
	localparam int N_RAND    = 40;
	localparam int N_BP      = 16;
	localparam int N_ROWS    = 24 + N_RAND + N_BP;
	localparam int TIMEOUT   = 5000;
	localparam int STALL     = 4 * XLEN;

	logic             clk;
	logic             rst_n_i;
	logic             req_valid_i;
	mdu_op_e          req_op_i;
	logic [TAG_W-1:0] req_tag_i;
	word_t            req_rs1_i;
	word_t            req_rs2_i;
	logic             req_credit_o;
	logic             res_credit_i;
	logic             res_valid_o;
	logic [TAG_W-1:0] res_tag_o;
	word_t            res_value_o;

	// stimulus and expected values
	mdu_op_e tab_op  [N_ROWS];
	word_t   tab_a   [N_ROWS];
	word_t   tab_b   [N_ROWS];
	word_t   tab_exp [N_ROWS];
	int      n_rows;
	int      n_mul;
	int      n_fixed;

	logic [TAG_W-1:0] exp_tag_q [$];
	word_t            exp_val_q [$];

	integer seed;
	int     req_credits;
	int     credit_pulses;
	int     sent_cnt;
	int     recv_cnt;
	int     granted;
	int     burst_left;
	int     err_cnt;
	bit     give_credit;
	bit     grant_en;
	bit     hold_mode;
	bit     aborted;

	`include "mdu_model.svh"

	mdu_top #(
		.REQ_DEPTH (REQ_DEPTH),
		.RES_DEPTH (RES_DEPTH)
	) mdu_top_inst (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (req_valid_i),
		.req_op_i     (req_op_i),
		.req_tag_i    (req_tag_i),
		.req_rs1_i    (req_rs1_i),
		.req_rs2_i    (req_rs2_i),
		.req_credit_o (req_credit_o),
		.res_credit_i (res_credit_i),
		.res_valid_o  (res_valid_o),
		.res_tag_o    (res_tag_o),
		.res_value_o  (res_value_o)
	);

	always #5 clk = ~clk;

	task automatic add_row(input mdu_op_e op, input word_t a, input word_t b);
		tab_op[n_rows]  = op;
		tab_a[n_rows]   = a;
		tab_b[n_rows]   = b;
		tab_exp[n_rows] = model_result(op, a, b);
		n_rows++;
	endtask

	// mostly random words, with corner values mixed in
	function automatic word_t pick_operand();
		word_t r;
		r = $random(seed);
		if (r[31:30] != 2'b00)
			return $random(seed);
		case (r[2:0])
			3'd0:    return 32'h0000_0000;
			3'd1:    return 32'h0000_0001;
			3'd2:    return 32'hffff_ffff;
			3'd3:    return 32'h8000_0000;
			3'd4:    return 32'h7fff_ffff;
			default: return r & 32'h0000_00ff;
		endcase
	endfunction

	task automatic fill_table;
		logic [31:0] rnd;
		n_rows = 0;
		add_row(op_mul, 32'd7, 32'd6);
		add_row(op_mul, 32'hffff_ffff, 32'h0000_0003);
		add_row(op_mul, 32'h8000_0000, 32'hffff_ffff);
		add_row(op_mulh, 32'hffff_fffe, 32'h0000_0005);
		add_row(op_mulh, 32'h8000_0000, 32'h8000_0000);
		add_row(op_mulh, 32'h7fff_ffff, 32'h7fff_ffff);
		add_row(op_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
		add_row(op_mulhsu, 32'h8000_0000, 32'h0000_0002);
		add_row(op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
		add_row(op_mulhu, 32'h1234_5678, 32'h9abc_def0);
		n_mul = n_rows;
		add_row(op_div, 32'd100, 32'd7);
		add_row(op_div, 32'hffff_ff9c, 32'd7);
		add_row(op_div, 32'd100, 32'hffff_fff9);
		add_row(op_div, 32'h8000_0000, 32'hffff_ffff);
		add_row(op_div, 32'd5, 32'd0);
		add_row(op_divu, 32'hffff_ffff, 32'd10);
		add_row(op_divu, 32'd5, 32'd0);
		add_row(op_rem, 32'hffff_ff9c, 32'd7);
		add_row(op_rem, 32'h8000_0000, 32'hffff_ffff);
		add_row(op_rem, 32'hffff_fff0, 32'd0);
		add_row(op_remu, 32'hffff_ffff, 32'd10);
		add_row(op_remu, 32'd9, 32'd0);
		n_fixed = n_rows;
		for (int i = 0; i < N_RAND + N_BP; i++) begin
			rnd = $random(seed);
			add_row(mdu_op_e'(rnd[2:0]), pick_operand(), pick_operand());
		end
	endtask

	task automatic check_result;
		logic [TAG_W-1:0] want_tag;
		word_t            want_val;
		recv_cnt++;
		if (hold_mode) begin
			$display("CHECK FAILED res_valid_o: expected %h, got %h", 1'b0, res_valid_o);
			err_cnt++;
		end
		if (exp_val_q.size() == 0) begin
			$display("ERROR: a result came back with no request outstanding");
			err_cnt++;
		end else begin
			want_tag = exp_tag_q.pop_front();
			want_val = exp_val_q.pop_front();
			if (res_tag_o !== want_tag) begin
				$display("CHECK FAILED res_tag_o: expected %h, got %h", want_tag, res_tag_o);
				err_cnt++;
			end
			if (res_value_o !== want_val) begin
				$display("CHECK FAILED res_value_o (tag %h): expected %h, got %h",
					want_tag, want_val, res_value_o);
				err_cnt++;
			end
		end
	endtask

	// credit returns, result checks and the downstream credit decision
	always @(negedge clk) begin
		if (!rst_n_i) begin
			give_credit = 1'b0;
		end else begin
			if (req_credit_o) begin
				req_credits++;
				credit_pulses++;
			end
			if (res_valid_o)
				check_result();
			if (burst_left == 0 && ($random(seed) & 3) == 0)
				burst_left = 1 + ($random(seed) & 3);
			// one credit per result still owed to the receiver
			give_credit = grant_en && burst_left > 0 &&
				(granted - recv_cnt) < exp_val_q.size();
			if (give_credit) begin
				granted++;
				burst_left--;
			end
		end
	end

	always @(posedge clk) begin
		res_credit_i <= give_credit;
	end

	task automatic wait_credit(input int limit, output bit got);
		int cnt;
		cnt = 0;
		while (req_credits == 0 && cnt < limit) begin
			@(posedge clk);
			req_valid_i <= 1'b0;
			cnt++;
		end
		got = (req_credits != 0);
	endtask

	task automatic drive_req(input int row);
		@(posedge clk);
		req_valid_i <= 1'b1;
		req_op_i    <= tab_op[row];
		req_tag_i   <= TAG_W'(sent_cnt);
		req_rs1_i   <= tab_a[row];
		req_rs2_i   <= tab_b[row];
		exp_tag_q.push_back(TAG_W'(sent_cnt));
		exp_val_q.push_back(tab_exp[row]);
		req_credits--;
		sent_cnt++;
	endtask

	task automatic send_rows(input int first, input int last);
		bit got;
		for (int i = first; i < last && !aborted; i++) begin
			wait_credit(TIMEOUT, got);
			if (!got) begin
				$display("ERROR: no request credit came back within %0d cycles", TIMEOUT);
				aborted = 1'b1;
			end else begin
				drive_req(i);
			end
		end
		@(posedge clk);
		req_valid_i <= 1'b0;
	endtask

	task automatic drain;
		int cnt;
		cnt = 0;
		while (exp_val_q.size() != 0 && cnt < TIMEOUT) begin
			@(posedge clk);
			cnt++;
		end
		if (exp_val_q.size() != 0) begin
			$display("ERROR: %0d results still missing after %0d cycles",
				exp_val_q.size(), TIMEOUT);
			aborted = 1'b1;
		end
	endtask

	task automatic check_idle(input int cycles);
		int errs_before;
		errs_before = err_cnt;
		repeat (cycles) begin
			@(negedge clk);
			if (res_valid_o !== 1'b0) begin
				$display("CHECK FAILED res_valid_o: expected %h, got %h", 1'b0, res_valid_o);
				err_cnt++;
			end
			if (req_credit_o !== 1'b0) begin
				$display("CHECK FAILED req_credit_o: expected %h, got %h", 1'b0, req_credit_o);
				err_cnt++;
			end
		end
		$display("test 1 idle after reset: %0d errors", err_cnt - errs_before);
	endtask

	task automatic run_test(input string name, input int first, input int last);
		int errs_before;
		errs_before = err_cnt;
		send_rows(first, last);
		if (!aborted)
			drain();
		$display("test %s: %0d requests, %0d errors", name, last - first,
			err_cnt - errs_before);
	endtask

	task automatic back_pressure(input int first, input int last);
		int errs_before;
		int row;
		bit got;
		errs_before = err_cnt;
		@(posedge clk);
		grant_en  = 1'b0;
		hold_mode = 1'b1;
		row       = first;
		got       = 1'b1;
		// send until the request credits stop coming back
		while (got && row < last) begin
			wait_credit(STALL, got);
			if (got) begin
				drive_req(row);
				row++;
			end
		end
		@(posedge clk);
		req_valid_i <= 1'b0;
		if (row == last) begin
			$display("ERROR: the request stream never stalled without result credits");
			err_cnt++;
		end
		if (sent_cnt - recv_cnt > REQ_DEPTH + RES_DEPTH + 1) begin
			$display("ERROR: %0d requests went unanswered, more than the DUT can hold",
				sent_cnt - recv_cnt);
			err_cnt++;
		end
		@(posedge clk);
		hold_mode = 1'b0;
		grant_en  = 1'b1;
		send_rows(row, last);
		if (!aborted)
			drain();
		if (!aborted && credit_pulses != sent_cnt) begin
			$display("CHECK FAILED req_credit_o pulse count: expected %h, got %h",
				sent_cnt, credit_pulses);
			err_cnt++;
		end
		$display("test 5 back-pressure: %0d requests, %0d errors", last - first,
			err_cnt - errs_before);
	endtask

	initial begin
		clk           = 1'b0;
		rst_n_i       = 1'b0;
		req_valid_i   = 1'b0;
		req_op_i      = op_mul;
		req_tag_i     = '0;
		req_rs1_i     = '0;
		req_rs2_i     = '0;
		res_credit_i  = 1'b0;
		seed          = 48425;
		req_credits   = REQ_DEPTH;
		credit_pulses = 0;
		sent_cnt      = 0;
		recv_cnt      = 0;
		granted       = 0;
		burst_left    = 0;
		err_cnt       = 0;
		give_credit   = 1'b0;
		grant_en      = 1'b0;
		hold_mode     = 1'b0;
		aborted       = 1'b0;
		fill_table();

		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;

		check_idle(20);
		@(posedge clk);
		grant_en = 1'b1;
		run_test("2 mul family", 0, n_mul);
		if (!aborted)
			run_test("3 div family", n_mul, n_fixed);
		if (!aborted)
			run_test("4 mixed order", n_fixed, n_fixed + N_RAND);
		if (!aborted)
			back_pressure(n_fixed + N_RAND, n_rows);

		$display("summary: %0d requests sent, %0d results received, %0d errors",
			sent_cnt, recv_cnt, err_cnt);
		if (aborted || err_cnt != 0)
			$display("Simulation FAILED");
		else
			$display("Simulation PASSED");
		$finish;
	end

endmodule : mdu_tb

// File: verilog.f
+incdir+testbench
logic/mdu_pkg.sv
logic/op_queue.sv
logic/shift_add_multiplier.sv
logic/restoring_divider.sv
logic/mdu_dispatch.sv
logic/result_sender.sv
logic/mdu_top.sv
testbench/mdu_tb.sv

// File: Bender.yml
package:
  name: mdu

sources:
  - logic/mdu_pkg.sv
  - logic/op_queue.sv
  - logic/shift_add_multiplier.sv
  - logic/restoring_divider.sv
  - logic/mdu_dispatch.sv
  - logic/result_sender.sv
  - logic/mdu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/mdu_tb.sv
